//--- Makefile
# Verilator flow for the cache control engine

TOP := tb_hpdcache_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -sv -f build.f --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -sv -f build.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
hpdcache_ctrl_pkg.sv
hpdcache_st1_if.sv
hpdcache_ctrl_stages.sv
hpdcache_st1_decide.sv
hpdcache_ctrl_top.sv
tb_ctrl_checker.sv
tb_hpdcache_ctrl.sv

//--- hpdcache_ctrl_pkg.sv
// Control engine package: request kind, request record, hold reasons
// and the fence rule
package hpdcache_ctrl_pkg;

    // Operation carried by a request
    typedef enum logic [2:0] {
        REQ_LOAD      = 3'd0,
        REQ_STORE     = 3'd1,
        REQ_AMO       = 3'd2,
        REQ_CMO_FENCE = 3'd3,
        REQ_CMO_INVAL = 3'd4
    } req_kind_e;

    // Request record as it moves from stage 0 to stage 2
    typedef struct packed {
        req_kind_e kind;
        logic      uncacheable;
        logic      need_rsp;
        // Issued by the replay table rather than the core
        logic      rtab;
    } ctrl_req_t;

    localparam int CTRL_REQ_W = $bits(ctrl_req_t);

    // Why a stage 1 request is parked in the replay table
    typedef enum logic [2:0] {
        HOLD_NONE           = 3'd0,
        HOLD_MSHR_HIT       = 3'd1,
        HOLD_MSHR_FULL      = 3'd2,
        HOLD_WBUF_HIT       = 3'd3,
        HOLD_WBUF_NOT_READY = 3'd4,
        HOLD_MSHR_NOT_READY = 3'd5
    } hold_reason_e;

    // Fences run in program order, everything before them drains first
    // and nothing after them starts until they are done
    function automatic logic is_fence(input ctrl_req_t req);
        return req.uncacheable            ||
               (req.kind == REQ_AMO)       ||
               (req.kind == REQ_CMO_FENCE) ||
               (req.kind == REQ_CMO_INVAL);
    endfunction

endpackage

//--- hpdcache_ctrl_stages.sv
`timescale 1ns/10ps
// Stage 0 admission, replay selection, stage 1 and 2 registers,
// refill grant and MSHR allocation
module hpdcache_ctrl_stages (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Cache state
    input  logic                         cachedir_init_ready_i,
    input  logic                         refill_busy_i,

    // Request and refill arbiter
    input  logic                         arb_st0_req_valid_i,
    input  hpdcache_ctrl_pkg::ctrl_req_t st0_req_i,
    output logic                         arb_st0_req_ready_o,
    input  logic                         arb_refill_valid_i,
    output logic                         arb_refill_ready_o,

    // Replay table and side handlers
    input  logic                         rtab_full_i,
    input  logic                         rtab_req_valid_i,
    input  logic                         rtab_check_hit_i,
    input  logic                         cmo_busy_i,
    input  logic                         uc_busy_i,
    output logic                         rtab_sel_o,
    output logic                         rtab_check_o,
    output logic                         st0_rtab_alloc_o,
    output logic                         mshr_alloc_o,

    hpdcache_st1_if.stage                st1
);
    import hpdcache_ctrl_pkg::*;

    logic      pipe_run;
    logic      st0_fence;
    logic      st2_nop;
    logic      st1_load;
    logic      st1_valid_q;
    ctrl_req_t st1_req_q;
    logic      st2_valid_q;
    ctrl_req_t st2_req_q;

    // Pipeline moves only once the directory is initialized and no refill owns it
    assign pipe_run  = cachedir_init_ready_i & ~refill_busy_i;
    assign st0_fence = is_fence(st0_req_i);

    // Replay table wins when full (a held core request would deadlock),
    // has a ready entry, or a fence or side operation is outstanding
    assign rtab_sel_o = rtab_full_i                          |
                        rtab_req_valid_i                     |
                        (st1_valid_q & is_fence(st1_req_q))  |
                        cmo_busy_i                           |
                        uc_busy_i;

    // Stage 2 miss takes the MSHR this cycle, bubble behind it
    assign mshr_alloc_o = pipe_run & st2_valid_q;
    assign st2_nop      = mshr_alloc_o;

    assign arb_st0_req_ready_o = pipe_run & arb_st0_req_valid_i & ~(st1.st1_nop | st2_nop);

    // Core requests are checked against pending replay entries
    assign rtab_check_o     = ~rtab_sel_o & arb_st0_req_ready_o & ~st0_fence;
    assign st0_rtab_alloc_o = rtab_check_o & rtab_check_hit_i;

    // Conflicting core request goes to the table, not to stage 1
    assign st1_load = arb_st0_req_ready_o & (rtab_sel_o | st0_fence | ~rtab_check_hit_i);

    // Refill only into an empty pipeline
    assign arb_refill_ready_o = pipe_run & arb_refill_valid_i & ~(st1_valid_q | st2_valid_q);

    assign st1.st1_valid = st1_valid_q;
    assign st1.st1_req   = st1_req_q;
    assign st1.rtab_sel  = rtab_sel_o;

    // Stage 1 always drains while running, stage 2 only gets misses
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            st1_valid_q <= 1'b0;
            st2_valid_q <= 1'b0;
        end else if (pipe_run) begin
            st1_valid_q <= st1_load;
            st2_valid_q <= st1.st2_fwd;
        end
    end

    always_ff @(posedge clk_i) begin
        if (st1_load) begin
            st1_req_q <= st0_req_i;
        end
        if (st1.st2_fwd) begin
            st2_req_q <= st1.st1_req;
        end
    end

    a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(arb_st0_req_ready_o) |-> arb_st0_req_valid_i);

    // Only cacheable loads reach the MSHR
    a_st2_cacheable_load: assert property (@(posedge clk_i) disable iff (reset_i)
        st2_valid_q |-> (st2_req_q.kind == REQ_LOAD) && !st2_req_q.uncacheable);

    // Held request never shows up in stage 2
    a_hold_not_fwd: assert property (@(posedge clk_i) disable iff (reset_i)
        st1.st1_rtab_alloc |=> !st2_valid_q);

endmodule

//--- hpdcache_ctrl_top.sv
`timescale 1ns/10ps
// Control engine top: request packing, stage registers and stage 1 decision
module hpdcache_ctrl_top (
    input  logic                            clk_i,
    input  logic                            reset_i,

    // Cache state
    input  logic                            cachedir_init_ready_i,
    input  logic                            refill_busy_i,
    input  logic                            cachedir_hit_i,

    // Request and refill arbiter
    input  logic                            arb_st0_req_valid_i,
    input  hpdcache_ctrl_pkg::req_kind_e    st0_req_kind_i,
    input  logic                            st0_req_uncacheable_i,
    input  logic                            st0_req_need_rsp_i,
    input  logic                            st0_req_rtab_i,
    output logic                            arb_st0_req_ready_o,
    input  logic                            arb_refill_valid_i,
    output logic                            arb_refill_ready_o,

    // Replay table
    input  logic                            rtab_full_i,
    input  logic                            rtab_req_valid_i,
    input  logic                            rtab_check_hit_i,
    output logic                            rtab_sel_o,
    output logic                            rtab_check_o,
    output logic                            st0_rtab_alloc_o,
    output logic                            rtab_alloc_o,
    output logic                            rtab_rback_o,
    output logic                            rtab_commit_o,
    output hpdcache_ctrl_pkg::hold_reason_e hold_reason_o,

    // MSHR and write buffer
    input  logic                            mshr_hit_i,
    input  logic                            mshr_full_i,
    input  logic                            mshr_alloc_ready_i,
    output logic                            mshr_alloc_o,
    input  logic                            wbuf_read_hit_i,
    input  logic                            wbuf_write_ready_i,
    output logic                            wbuf_write_valid_o,

    // Core response and side handlers
    output logic                            rsp_valid_o,
    input  logic                            cmo_busy_i,
    input  logic                            uc_busy_i,
    output logic                            uc_req_valid_o,
    output logic                            cmo_req_valid_o
);
    import hpdcache_ctrl_pkg::*;

    ctrl_req_t st0_req;
    logic      st0_load_pending;

    assign st0_req = '{
        kind:        st0_req_kind_i,
        uncacheable: st0_req_uncacheable_i,
        need_rsp:    st0_req_need_rsp_i,
        rtab:        st0_req_rtab_i
    };

    // Cacheable load waiting in stage 0, clashes with a stage 1 store
    assign st0_load_pending = arb_st0_req_valid_i & (st0_req_kind_i == REQ_LOAD) &
                              ~st0_req_uncacheable_i;

    hpdcache_st1_if st1_if (
        .clk_i   (clk_i),
        .reset_i (reset_i)
    );

    hpdcache_ctrl_stages u_stages (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .cachedir_init_ready_i (cachedir_init_ready_i),
        .refill_busy_i         (refill_busy_i),
        .arb_st0_req_valid_i   (arb_st0_req_valid_i),
        .st0_req_i             (st0_req),
        .arb_st0_req_ready_o   (arb_st0_req_ready_o),
        .arb_refill_valid_i    (arb_refill_valid_i),
        .arb_refill_ready_o    (arb_refill_ready_o),
        .rtab_full_i           (rtab_full_i),
        .rtab_req_valid_i      (rtab_req_valid_i),
        .rtab_check_hit_i      (rtab_check_hit_i),
        .cmo_busy_i            (cmo_busy_i),
        .uc_busy_i             (uc_busy_i),
        .rtab_sel_o            (rtab_sel_o),
        .rtab_check_o          (rtab_check_o),
        .st0_rtab_alloc_o      (st0_rtab_alloc_o),
        .mshr_alloc_o          (mshr_alloc_o),
        .st1                   (st1_if.stage)
    );

    hpdcache_st1_decide u_decide (
        .cachedir_init_ready_i (cachedir_init_ready_i),
        .refill_busy_i         (refill_busy_i),
        .cachedir_hit_i        (cachedir_hit_i),
        .mshr_hit_i            (mshr_hit_i),
        .mshr_full_i           (mshr_full_i),
        .mshr_alloc_ready_i    (mshr_alloc_ready_i),
        .wbuf_read_hit_i       (wbuf_read_hit_i),
        .wbuf_write_ready_i    (wbuf_write_ready_i),
        .st0_load_pending_i    (st0_load_pending),
        .st1                   (st1_if.decide),
        .rsp_valid_o           (rsp_valid_o),
        .uc_req_valid_o        (uc_req_valid_o),
        .cmo_req_valid_o       (cmo_req_valid_o),
        .wbuf_write_valid_o    (wbuf_write_valid_o),
        .rtab_alloc_o          (rtab_alloc_o),
        .rtab_rback_o          (rtab_rback_o),
        .rtab_commit_o         (rtab_commit_o),
        .hold_reason_o         (hold_reason_o)
    );

endmodule

//--- hpdcache_st1_decide.sv
`timescale 1ns/10ps
// Stage 1 decision for fences, loads and stores, hold reasons and replay commit
module hpdcache_st1_decide (
    // Cache state
    input  logic                            cachedir_init_ready_i,
    input  logic                            refill_busy_i,
    input  logic                            cachedir_hit_i,

    // MSHR and write buffer
    input  logic                            mshr_hit_i,
    input  logic                            mshr_full_i,
    input  logic                            mshr_alloc_ready_i,
    input  logic                            wbuf_read_hit_i,
    input  logic                            wbuf_write_ready_i,

    // Cacheable load offered in stage 0
    input  logic                            st0_load_pending_i,

    hpdcache_st1_if.decide                  st1,

    // Stage 1 results
    output logic                            rsp_valid_o,
    output logic                            uc_req_valid_o,
    output logic                            cmo_req_valid_o,
    output logic                            wbuf_write_valid_o,
    output logic                            rtab_alloc_o,
    output logic                            rtab_rback_o,
    output logic                            rtab_commit_o,
    output hpdcache_ctrl_pkg::hold_reason_e hold_reason_o
);
    import hpdcache_ctrl_pkg::*;

    logic      st1_run;
    logic      st1_nop;
    logic      st2_fwd;
    logic      hold;
    ctrl_req_t req;

    assign req     = st1.st1_req;
    assign st1_run = st1.st1_valid & cachedir_init_ready_i & ~refill_busy_i;

    always_comb begin
        rsp_valid_o        = 1'b0;
        uc_req_valid_o     = 1'b0;
        cmo_req_valid_o    = 1'b0;
        wbuf_write_valid_o = 1'b0;
        rtab_commit_o      = 1'b0;
        st1_nop            = 1'b0;
        st2_fwd            = 1'b0;
        hold_reason_o      = HOLD_NONE;

        if (st1_run) begin
            // Cache maintenance goes to the CMO handler
            if ((req.kind == REQ_CMO_FENCE) || (req.kind == REQ_CMO_INVAL)) begin
                cmo_req_valid_o = 1'b1;
                st1_nop         = 1'b1;
            end else if (req.uncacheable || (req.kind == REQ_AMO)) begin
                // Uncached accesses and all AMOs
                uc_req_valid_o = 1'b1;
                st1_nop        = 1'b1;
            end else if (req.kind == REQ_LOAD) begin
                if (!cachedir_hit_i) begin
                    // Miss stalls stage 0 whatever happens next
                    st1_nop = 1'b1;
                    if (mshr_hit_i) begin
                        hold_reason_o = HOLD_MSHR_HIT;
                    end else if (mshr_full_i) begin
                        hold_reason_o = HOLD_MSHR_FULL;
                    end else if (wbuf_read_hit_i) begin
                        // Open write buffer entry must be acknowledged first
                        hold_reason_o = HOLD_WBUF_HIT;
                    end else if (!mshr_alloc_ready_i) begin
                        // Leave room for refill responses to drain
                        hold_reason_o = HOLD_MSHR_NOT_READY;
                    end else begin
                        rtab_commit_o = req.rtab;
                        st2_fwd       = 1'b1;
                    end
                end else begin
                    rtab_commit_o = req.rtab;
                    rsp_valid_o   = req.need_rsp;
                    // Replayed hit, only another replay may follow
                    st1_nop       = req.rtab & ~st1.rtab_sel;
                end
            end else if (req.kind == REQ_STORE) begin
                // Read and write channels are unordered, wait on a pending miss
                wbuf_write_valid_o = ~mshr_hit_i;
                // Data RAM conflict with a load behind us
                st1_nop = st0_load_pending_i | (req.rtab & ~st1.rtab_sel);
                if (!cachedir_hit_i && mshr_hit_i) begin
                    hold_reason_o = HOLD_MSHR_HIT;
                    st1_nop       = 1'b1;
                end else if (!wbuf_write_ready_i) begin
                    hold_reason_o = HOLD_WBUF_NOT_READY;
                    st1_nop       = 1'b1;
                end else begin
                    rtab_commit_o = req.rtab;
                    rsp_valid_o   = req.need_rsp;
                end
            end
        end
    end

    assign hold = (hold_reason_o != HOLD_NONE);

    // New entry for core requests, rollback for replayed ones
    assign rtab_alloc_o = hold & ~req.rtab;
    assign rtab_rback_o = hold &  req.rtab;

    assign st1.st1_nop        = st1_nop;
    assign st1.st2_fwd        = st2_fwd;
    assign st1.st1_rtab_alloc = hold;

    a_uc_cmo_excl: assert property (@(posedge st1.clk_i) disable iff (st1.reset_i)
        !(uc_req_valid_o && cmo_req_valid_o));

    // Held request is neither answered, committed nor passed on to stage 2
    a_hold_not_done: assert property (@(posedge st1.clk_i) disable iff (st1.reset_i)
        (hold_reason_o != HOLD_NONE) |->
            st1_nop && !st2_fwd && !rsp_valid_o && !rtab_commit_o);

endmodule

//--- hpdcache_st1_if.sv
`timescale 1ns/10ps
// Stage 1 bundle between the stage registers and the decision logic
interface hpdcache_st1_if (
    input logic clk_i,
    input logic reset_i
);
    import hpdcache_ctrl_pkg::*;

    // From the stage registers
    logic      st1_valid;
    ctrl_req_t st1_req;
    // Upstream arbiter prefers the replay table
    logic      rtab_sel;

    // From the decision logic
    // Do not consume a stage 0 request this cycle
    logic      st1_nop;
    logic      st2_fwd;
    logic      st1_rtab_alloc;

    modport stage (
        output st1_valid, st1_req, rtab_sel,
        input  st1_nop, st2_fwd, st1_rtab_alloc
    );

    modport decide (
        input  clk_i, reset_i,
        input  st1_valid, st1_req, rtab_sel,
        output st1_nop, st2_fwd, st1_rtab_alloc
    );

endinterface

//--- tb_ctrl_checker.sv
`timescale 1ns/10ps
// Checker: stage 1 reference model, stage tracking and output comparison
module tb_ctrl_checker (
    input  logic                            clk_i, reset_i,
    input  logic                            cachedir_init_ready_i, refill_busy_i, cachedir_hit_i,
    input  logic                            arb_st0_req_valid_i,
    input  hpdcache_ctrl_pkg::req_kind_e    st0_req_kind_i,
    input  logic                            st0_req_uncacheable_i, st0_req_need_rsp_i,
    input  logic                            st0_req_rtab_i,
    input  logic                            arb_st0_req_ready_o, arb_refill_valid_i,
    input  logic                            arb_refill_ready_o,
    input  logic                            rtab_full_i, rtab_req_valid_i, rtab_check_hit_i,
    input  logic                            rtab_sel_o, rtab_check_o, st0_rtab_alloc_o,
    input  logic                            rtab_alloc_o, rtab_rback_o, rtab_commit_o,
    input  hpdcache_ctrl_pkg::hold_reason_e hold_reason_o,
    input  logic                            mshr_hit_i, mshr_full_i, mshr_alloc_ready_i,
    input  logic                            mshr_alloc_o,
    input  logic                            wbuf_read_hit_i, wbuf_write_ready_i,
    input  logic                            wbuf_write_valid_o, rsp_valid_o,
    input  logic                            cmo_busy_i, uc_busy_i,
    input  logic                            uc_req_valid_o, cmo_req_valid_o,
    output int                              errors_o
);
    import hpdcache_ctrl_pkg::*;

    // Expected stage 1 results, plus the stall and forward decisions
    typedef struct packed {
        logic         rsp, uc, cmo, wbuf_wr, alloc, rback, commit, nop, fwd;
        hold_reason_e reason;
    } st1_exp_t;

    int        errors = 0;
    // Model of the two stage registers
    logic      st1_v = 1'b0;
    logic      st2_v = 1'b0;
    ctrl_req_t st1_req = '0;
    ctrl_req_t st0_req;
    st1_exp_t  want;
    logic      run, sel, ld_pend, ready_exp, check_exp, alloc_exp, st1_load;

    assign errors_o = errors;

    // Fate of a stage 1 request given the environment seen in that cycle
    function automatic st1_exp_t predict_st1(input logic valid, input ctrl_req_t req,
                                             input logic hit, mshr_hit, mshr_full,
                                             input logic alloc_ready, wbuf_hit, wbuf_ready,
                                             input logic ld_pend_i, sel_i);
        st1_exp_t e;
        logic     load, store, miss, hold, done;
        e     = '0;
        load  = !req.uncacheable && (req.kind == REQ_LOAD);
        store = !req.uncacheable && (req.kind == REQ_STORE);
        miss  = !hit;
        if (!valid) begin
            return e;
        end
        // CMO kinds go to the CMO handler even when uncacheable
        e.cmo = (req.kind == REQ_CMO_FENCE) || (req.kind == REQ_CMO_INVAL);
        e.uc  = !e.cmo && is_fence(req);
        e.reason = HOLD_NONE;
        if (load && miss) begin
            if (mshr_hit)          e.reason = HOLD_MSHR_HIT;
            else if (mshr_full)    e.reason = HOLD_MSHR_FULL;
            else if (wbuf_hit)     e.reason = HOLD_WBUF_HIT;
            else if (!alloc_ready) e.reason = HOLD_MSHR_NOT_READY;
        end
        if (store) begin
            e.wbuf_wr = !mshr_hit;
            if (miss && mshr_hit)  e.reason = HOLD_MSHR_HIT;
            else if (!wbuf_ready)  e.reason = HOLD_WBUF_NOT_READY;
        end
        hold     = (e.reason != HOLD_NONE);
        done     = (load || store) && !hold;
        e.fwd    = load && miss && !hold;
        // Forwarded misses answer later, from the refill
        e.rsp    = done && !e.fwd && req.need_rsp;
        e.commit = done && req.rtab;
        e.alloc  = hold && !req.rtab;
        e.rback  = hold && req.rtab;
        e.nop    = is_fence(req) || hold || (load && miss) || (store && ld_pend_i) ||
                   ((load || store) && req.rtab && !sel_i);
        return e;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_reason(input hold_reason_e got, input hold_reason_e exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: hold_reason_o is %0d, expected %0d", $time, got, exp);
        end
    endtask

    // Mid-cycle sampling, inputs and registers are settled here
    always @(negedge clk_i) begin
        run     = cachedir_init_ready_i & ~refill_busy_i;
        st0_req = '{kind: st0_req_kind_i, uncacheable: st0_req_uncacheable_i,
                    need_rsp: st0_req_need_rsp_i, rtab: st0_req_rtab_i};
        ld_pend = arb_st0_req_valid_i & (st0_req_kind_i == REQ_LOAD) &
                  ~st0_req_uncacheable_i;
        sel     = rtab_full_i | rtab_req_valid_i | cmo_busy_i | uc_busy_i |
                  (st1_v & is_fence(st1_req));
        want    = predict_st1(st1_v & run, st1_req, cachedir_hit_i, mshr_hit_i,
                              mshr_full_i, mshr_alloc_ready_i, wbuf_read_hit_i,
                              wbuf_write_ready_i, ld_pend, sel);
        // Stage 2 miss takes the MSHR and leaves a bubble
        alloc_exp = run & st2_v;
        ready_exp = run & arb_st0_req_valid_i & ~want.nop & ~alloc_exp;
        check_exp = ready_exp & ~sel & ~is_fence(st0_req);

        check_bit("arb_st0_req_ready_o", arb_st0_req_ready_o, ready_exp);
        check_bit("arb_refill_ready_o", arb_refill_ready_o,
                  run & arb_refill_valid_i & ~st1_v & ~st2_v);
        check_bit("rtab_sel_o", rtab_sel_o, sel);
        check_bit("rtab_check_o", rtab_check_o, check_exp);
        check_bit("st0_rtab_alloc_o", st0_rtab_alloc_o, check_exp & rtab_check_hit_i);
        check_bit("mshr_alloc_o", mshr_alloc_o, alloc_exp);
        check_bit("rsp_valid_o", rsp_valid_o, want.rsp);
        check_bit("uc_req_valid_o", uc_req_valid_o, want.uc);
        check_bit("cmo_req_valid_o", cmo_req_valid_o, want.cmo);
        check_bit("wbuf_write_valid_o", wbuf_write_valid_o, want.wbuf_wr);
        check_bit("rtab_alloc_o", rtab_alloc_o, want.alloc);
        check_bit("rtab_rback_o", rtab_rback_o, want.rback);
        check_bit("rtab_commit_o", rtab_commit_o, want.commit);
        check_reason(hold_reason_o, want.reason);

        // Next state, stages clear on reset and freeze while the pipeline is stopped
        if (reset_i) begin
            st1_v = 1'b0;
            st2_v = 1'b0;
        end else if (run) begin
            // A conflicting core request is parked instead
            st1_load = ready_exp & ~(check_exp & rtab_check_hit_i);
            if (st1_load) begin
                st1_req = st0_req;
            end
            st1_v = st1_load;
            st2_v = want.fwd;
        end
    end

endmodule

//--- tb_hpdcache_ctrl.sv
`timescale 1ns/10ps
// Testbench top: clock, reset, directed and seeded random stimulus, closing report
module tb_hpdcache_ctrl;
    import hpdcache_ctrl_pkg::*;

    localparam int WAIT_LIMIT  = 50;
    localparam int RAND_CYCLES = 4000;

    logic         clk_i = 1'b0;
    logic         reset_i;
    logic         cachedir_init_ready_i, refill_busy_i, cachedir_hit_i;
    logic         arb_st0_req_valid_i, arb_st0_req_ready_o;
    req_kind_e    st0_req_kind_i;
    logic         st0_req_uncacheable_i, st0_req_need_rsp_i, st0_req_rtab_i;
    logic         arb_refill_valid_i, arb_refill_ready_o;
    logic         rtab_full_i, rtab_req_valid_i, rtab_check_hit_i;
    logic         rtab_sel_o, rtab_check_o, st0_rtab_alloc_o;
    logic         rtab_alloc_o, rtab_rback_o, rtab_commit_o;
    hold_reason_e hold_reason_o;
    logic         mshr_hit_i, mshr_full_i, mshr_alloc_ready_i, mshr_alloc_o;
    logic         wbuf_read_hit_i, wbuf_write_ready_i, wbuf_write_valid_o;
    logic         rsp_valid_o, cmo_busy_i, uc_busy_i, uc_req_valid_o, cmo_req_valid_o;
    int           errors_o;
    int           timeouts = 0;
    integer       seed = 32'h1525_d0ed;

    always #5 clk_i = ~clk_i;

    hpdcache_ctrl_top UUT (.*);

    tb_ctrl_checker u_checker (.*);

    // Quiet environment, everything ready and hitting
    task automatic drive_idle(input logic init_ready);
        cachedir_init_ready_i = init_ready;
        refill_busy_i         = 1'b0;
        cachedir_hit_i        = 1'b1;
        arb_st0_req_valid_i   = 1'b0;
        st0_req_kind_i        = REQ_LOAD;
        st0_req_uncacheable_i = 1'b0;
        st0_req_need_rsp_i    = 1'b0;
        st0_req_rtab_i        = 1'b0;
        arb_refill_valid_i    = 1'b0;
        rtab_full_i           = 1'b0;
        rtab_req_valid_i      = 1'b0;
        rtab_check_hit_i      = 1'b0;
        mshr_hit_i            = 1'b0;
        mshr_full_i           = 1'b0;
        mshr_alloc_ready_i    = 1'b1;
        wbuf_read_hit_i       = 1'b0;
        wbuf_write_ready_i    = 1'b1;
        cmo_busy_i            = 1'b0;
        uc_busy_i             = 1'b0;
    endtask

    // Biased draws so that holds, stalls and replays all show up
    task automatic drive_random();
        ctrl_req_t req;
        cachedir_init_ready_i = (($random(seed) & 31) != 0);
        refill_busy_i         = (($random(seed) & 15) == 0);
        cachedir_hit_i        = (($random(seed) & 1) != 0);
        arb_st0_req_valid_i   = (($random(seed) & 3) != 0);
        // Whole record drawn at once, kind folded onto the defined operations
        req                   = ctrl_req_t'(CTRL_REQ_W'($random(seed)));
        st0_req_kind_i        = req_kind_e'(3'(req.kind % 5));
        st0_req_uncacheable_i = (($random(seed) & 7) == 0);
        st0_req_need_rsp_i    = req.need_rsp;
        st0_req_rtab_i        = (($random(seed) & 3) == 0);
        arb_refill_valid_i    = (($random(seed) & 7) == 0);
        rtab_full_i           = (($random(seed) & 15) == 0);
        rtab_req_valid_i      = (($random(seed) & 7) == 0);
        rtab_check_hit_i      = (($random(seed) & 3) == 0);
        mshr_hit_i            = (($random(seed) & 3) == 0);
        mshr_full_i           = (($random(seed) & 7) == 0);
        mshr_alloc_ready_i    = (($random(seed) & 7) != 0);
        wbuf_read_hit_i       = (($random(seed) & 7) == 0);
        wbuf_write_ready_i    = (($random(seed) & 7) != 0);
        cmo_busy_i            = (($random(seed) & 15) == 0);
        uc_busy_i             = (($random(seed) & 15) == 0);
    endtask

    // Offer one request and hold it until the handshake
    task automatic send_req(input req_kind_e kind, input logic unc, rsp, rtab);
        int n;
        arb_st0_req_valid_i   = 1'b1;
        st0_req_kind_i        = kind;
        st0_req_uncacheable_i = unc;
        st0_req_need_rsp_i    = rsp;
        st0_req_rtab_i        = rtab;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk_i);
            if (arb_st0_req_ready_o) break;
        end
        if (n == WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout at %0t: request of kind %0d was never accepted", $time, kind);
        end
        @(posedge clk_i);
        #1;
        arb_st0_req_valid_i = 1'b0;
    endtask

    // Refill is granted once both stages have drained
    task automatic wait_refill_grant();
        int n;
        arb_refill_valid_i = 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk_i);
            if (arb_refill_ready_o) break;
        end
        if (n == WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout at %0t: refill was never granted", $time);
        end
        @(posedge clk_i);
        #1;
        arb_refill_valid_i = 1'b0;
    endtask

    initial begin
        reset_i = 1'b1;
        drive_idle(1'b0);
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Directory still initializing, nothing may be accepted
        arb_st0_req_valid_i = 1'b1;
        arb_refill_valid_i  = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        drive_idle(1'b1);

        send_req(REQ_LOAD, 1'b0, 1'b1, 1'b0);
        send_req(REQ_STORE, 1'b0, 1'b1, 1'b0);
        send_req(REQ_CMO_FENCE, 1'b0, 1'b0, 1'b0);
        send_req(REQ_AMO, 1'b0, 1'b1, 1'b0);
        send_req(REQ_LOAD, 1'b1, 1'b1, 1'b0);
        send_req(REQ_LOAD, 1'b0, 1'b1, 1'b1);
        // Misses from here on, the last load goes to the MSHR
        cachedir_hit_i = 1'b0;
        send_req(REQ_LOAD, 1'b0, 1'b1, 1'b0);
        wait_refill_grant();

        repeat (RAND_CYCLES) begin
            @(posedge clk_i);
            #1;
            drive_random();
        end

        @(posedge clk_i);
        #1;
        drive_idle(1'b1);
        wait_refill_grant();

        $display("Closing report: %0d check errors, %0d timeouts", errors_o, timeouts);
        if ((errors_o == 0) && (timeouts == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
